// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_cnn_loader
FILELIST = sim.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/loader_cases.txt
# name  op  f1  f2  f3  f4
# init and layer: f1 layer_num, f2 fm_count, f3 weight_count, f4 kernel_count
# update: f1 cur_count, f2 next_count, f3 and f4 unused
# idle: f1 cycles to watch both done flags stay low
idle_after_reset    idle    10   0   0   0
init_fill           init     0  20   7   0
conv_layer          layer    1   0   0   3
update_kernels_a    update   4   2   0   0
update_kernels_b    update   4   2   0   0
update_next_layer   update   3   5   0   0
update_next_empty   update   3   0   0   0
restart_init        init     2   6   3   0
init_zero_counts    init     3   0   0   0

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period_ns / 2) clk = ~clk;   // 50% duty

endmodule

// File: bench/tb_cnn_loader.sv
`timescale 1ns/1ps

module tb_cnn_loader;
    import cnn_params_pkg::*;
    import cnn_types_pkg::*;

    localparam int clk_period_ns = 100;
    localparam int reset_cycles = 4;

    logic                         clk;
    logic                         rst;
    logic                         layer_start;
    layer_cfg_t                   layer_cfg;
    logic                         update_start;
    weight_req_t                  weight_req;
    logic [fm_addr_width-1:0]     fm_rd_addr;
    logic [weight_addr_width-1:0] weight_rd_addr;
    logic                         fm_done;
    logic                         weight_done;
    logic [fm_word_width-1:0]     fm_rd_data;
    logic [weight_word_width-1:0] weight_rd_data;

    logic [fm_word_width-1:0]     fm_shadow [fm_depth];
    bit                           fm_valid [fm_depth];
    logic [weight_word_width-1:0] wt_shadow [weight_depth];
    bit                           wt_valid [weight_depth];

    string case_name[$];
    string case_op[$];
    int    case_f1[$];
    int    case_f2[$];
    int    case_f3[$];
    int    case_f4[$];

    int   seed = 24;
    int   budget_cycles = 0;
    int   kernels_left = 0;   // predicted engine state
    logic fm_flag = 1'b0;     // expected done levels between tests
    logic wt_flag = 1'b0;
    int   test_errors;
    int   failed_tests = 0;
    int   total_errors = 0;

    tb_clock_gen #(.period_ns(clk_period_ns)) clock_inst (.clk(clk));

    cnn_loader_top cnn_loader_top_inst (
        .clk            (clk),
        .rst            (rst),
        .layer_start    (layer_start),
        .layer_cfg      (layer_cfg),
        .update_start   (update_start),
        .weight_req     (weight_req),
        .fm_rd_addr     (fm_rd_addr),
        .weight_rd_addr (weight_rd_addr),
        .fm_done        (fm_done),
        .weight_done    (weight_done),
        .fm_rd_data     (fm_rd_data),
        .weight_rd_data (weight_rd_data)
    );

    // exact float16 of a non-negative integer, taken modulo 2048
    function automatic logic [15:0] to_half(input int value);
        int v;
        int e;
        v = value % 2048;
        e = 0;
        if (v == 0) begin
            return 16'h0000;
        end
        while ((v >> (e + 1)) != 0) begin
            e++;
        end
        return {1'b0, 5'(e + 15), 10'((v - (1 << e)) << (10 - e))};
    endfunction

    function automatic logic [fm_word_width-1:0] fm_ramp_word(input int k);
        logic [fm_word_width-1:0] w;
        for (int i = 0; i < fm_lanes; i++) begin
            w[i*data_width +: data_width] = to_half(k * fm_lanes + i);
        end
        return w;
    endfunction

    function automatic logic [weight_word_width-1:0] weight_ramp_word(input int k);
        logic [weight_word_width-1:0] w;
        for (int i = 0; i < weight_lanes; i++) begin
            w[i*data_width +: data_width] = to_half(k * weight_lanes + i);
        end
        return w;
    endfunction

    task automatic compare_fm(input string name, input int addr,
                              input logic [fm_word_width-1:0] exp,
                              input logic [fm_word_width-1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s fm[%0d]: expected %h, actual %h", name, addr, exp, act);
            test_errors++;
        end
    endtask

    task automatic compare_weight(input string name, input int addr,
                                  input logic [weight_word_width-1:0] exp,
                                  input logic [weight_word_width-1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s weight[%0d]: expected %h, actual %h", name, addr, exp, act);
            test_errors++;
        end
    endtask

    task automatic compare_flag(input string name, input string flag,
                                input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %b, actual %b", name, flag, exp, act);
            test_errors++;
        end
    endtask

    // checks done levels every cycle until the flags of this transfer are up
    task automatic wait_done(input string name, input bit fm_used, input int fm_n,
                             input int wt_n);
        int cyc;
        int limit;
        cyc = 0;
        limit = ((fm_n > wt_n) ? fm_n : wt_n) + 10;
        do begin
            @(posedge clk);
            #1;
            cyc++;
            layer_start = 1'b0;
            update_start = 1'b0;
            compare_flag(name, "fm_done", fm_used ? logic'(cyc >= fm_n + 1) : fm_flag, fm_done);
            compare_flag(name, "weight_done", logic'(cyc >= wt_n + 1), weight_done);
        end while (!(weight_done && (fm_done || !fm_used)) && cyc < limit);
        if (!(weight_done && (fm_done || !fm_used))) begin
            $display("%s: done flag did not rise within %0d cycles", name, limit);
            test_errors++;
        end
        fm_flag = fm_used ? 1'b1 : fm_flag;
        wt_flag = 1'b1;
    endtask

    task automatic hold_flags(input string name, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            layer_start = 1'b0;
            compare_flag(name, "fm_done", fm_flag, fm_done);
            compare_flag(name, "weight_done", wt_flag, weight_done);
        end
    endtask

    // reads back every address written so far, one per cycle
    task automatic sweep_buffers(input string name);
        int a;
        for (a = 0; a < fm_depth; a++) begin
            if (fm_valid[a]) begin
                fm_rd_addr = fm_addr_width'(a);
                @(posedge clk);
                #1;
                compare_fm(name, a, fm_shadow[a], fm_rd_data);
            end
        end
        for (a = 0; a < weight_depth; a++) begin
            if (wt_valid[a]) begin
                weight_rd_addr = weight_addr_width'(a);
                @(posedge clk);
                #1;
                compare_weight(name, a, wt_shadow[a], weight_rd_data);
            end
        end
    endtask

    task automatic run_init(input string name, input int num, input int fm_n, input int wt_n);
        int half;
        int addr;
        half = wt_n / 2;
        for (int k = 0; k < fm_n; k++) begin
            fm_shadow[k] = fm_ramp_word(k);
            fm_valid[k] = 1'b1;
        end
        for (int k = 0; k < wt_n; k++) begin
            addr = (k < half) ? k * weight_addr_step : weight_ram_half + (k - half) * weight_addr_step;
            wt_shadow[addr] = weight_ramp_word(k);
            wt_valid[addr] = 1'b1;
        end
        layer_cfg.layer_type = layer_init;
        layer_cfg.layer_num = layer_num_width'(num);
        layer_cfg.fm_count = count_width'(fm_n);
        layer_cfg.weight_count = count_width'(wt_n);
        layer_cfg.kernel_count = '0;
        layer_start = 1'b1;
        wait_done(name, 1'b1, fm_n, wt_n);
        sweep_buffers(name);
    endtask

    task automatic run_layer(input string name, input int num, input int kernels);
        layer_cfg.layer_type = layer_conv;
        layer_cfg.layer_num = layer_num_width'(num);
        layer_cfg.fm_count = '0;
        layer_cfg.weight_count = '0;
        layer_cfg.kernel_count = count_width'(kernels);
        layer_start = 1'b1;
        kernels_left = kernels;
        hold_flags(name, 3);   // no writes, flags keep their level
    endtask

    task automatic run_update(input string name, input int cur, input int nxt);
        int base;
        int n;
        int addr;
        base = ({$random(seed)} % 28) * weight_addr_step;   // below the upper half
        if (kernels_left != 0) begin
            n = cur;
            kernels_left = (kernels_left > para_kernel) ? kernels_left - para_kernel : 0;
        end else begin
            n = nxt;
        end
        $display("%s: base_addr %0d, %0d words, kernels left %0d", name, base, n, kernels_left);
        for (int k = 0; k < n; k++) begin
            addr = (base + k * weight_addr_step) % weight_depth;
            wt_shadow[addr] = weight_ramp_word(k);
            wt_valid[addr] = 1'b1;
        end
        weight_req.base_addr = weight_addr_width'(base);
        weight_req.cur_count = count_width'(cur);
        weight_req.next_count = count_width'(nxt);
        update_start = 1'b1;
        wait_done(name, 1'b0, 0, n);
        sweep_buffers(name);
    endtask

    initial begin
        int    fd;
        int    n;
        int    f1;
        int    f2;
        int    f3;
        int    f4;
        int    total;
        string line;
        string name;
        string op;
        rst = 1'b0;
        layer_start = 1'b0;
        update_start = 1'b0;
        layer_cfg = '0;
        weight_req = '0;
        fm_rd_addr = '0;
        weight_rd_addr = '0;
        fd = $fopen("bench/loader_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file bench/loader_cases.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            total = 0;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%s %s %d %d %d %d", name, op, f1, f2, f3, f4);
                    if (n == 6) begin
                        case_name.push_back(name);
                        case_op.push_back(op);
                        case_f1.push_back(f1);
                        case_f2.push_back(f2);
                        case_f3.push_back(f3);
                        case_f4.push_back(f4);
                        if (op == "init" || op == "layer") begin
                            total += f2 + f3;
                        end else begin
                            total += f1 + f2;
                        end
                    end
                end
            end
            $fclose(fd);
            budget_cycles = total + 50 * case_name.size() + reset_cycles + 10;
            repeat (reset_cycles) @(posedge clk);
            #1;
            rst = 1'b1;
            foreach (case_name[i]) begin
                test_errors = 0;
                case (case_op[i])
                    "idle":   hold_flags(case_name[i], case_f1[i]);
                    "init":   run_init(case_name[i], case_f1[i], case_f2[i], case_f3[i]);
                    "layer":  run_layer(case_name[i], case_f1[i], case_f4[i]);
                    "update": run_update(case_name[i], case_f1[i], case_f2[i]);
                    default: begin
                        $display("%s: unknown operation %s", case_name[i], case_op[i]);
                        test_errors++;
                    end
                endcase
                if (test_errors == 0) begin
                    $display("PASS  %s", case_name[i]);
                end else begin
                    $display("FAIL  %s (%0d errors)", case_name[i], test_errors);
                    failed_tests++;
                end
                total_errors += test_errors;
            end
            $display("tests %0d, failed %0d, errors %0d", case_name.size(), failed_tests,
                     total_errors);
            if (case_name.size() > 0 && failed_tests == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (budget_cycles > 0);
        #(budget_cycles * clk_period_ns);
        $display("Timeout: the tests did not finish within %0d clock cycles", budget_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: sim.f
source/cnn_params_pkg.sv
source/cnn_types_pkg.sv
source/fp16_ramp_gen.sv
source/buffer_ram.sv
source/data_trans_fp16.sv
source/cnn_loader_top.sv
bench/tb_clock_gen.sv
bench/tb_cnn_loader.sv

// File: source/buffer_ram.sv
`timescale 1ns/1ps

module buffer_ram #(
    parameter int width = 64,
    parameter int depth = 64
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(depth)-1:0] wr_addr,
    input  logic [width-1:0]         wr_data,
    input  logic [$clog2(depth)-1:0] rd_addr,
    output logic [width-1:0]         rd_data
);

    logic [width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];   // same-address collision returns old word
    end

    assert property (@(posedge clk) wr_en |-> (int'(wr_addr) < depth))
        else $error("buffer write beyond depth");

endmodule

// File: source/cnn_loader_top.sv
`timescale 1ns/1ps

module cnn_loader_top (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           layer_start,
    input  cnn_types_pkg::layer_cfg_t                      layer_cfg,
    input  logic                                           update_start,
    input  cnn_types_pkg::weight_req_t                     weight_req,
    input  logic [cnn_params_pkg::fm_addr_width-1:0]       fm_rd_addr,
    input  logic [cnn_params_pkg::weight_addr_width-1:0]   weight_rd_addr,
    output logic                                           fm_done,
    output logic                                           weight_done,
    output logic [cnn_params_pkg::fm_word_width-1:0]       fm_rd_data,
    output logic [cnn_params_pkg::weight_word_width-1:0]   weight_rd_data
);
    import cnn_params_pkg::*;
    import cnn_types_pkg::*;

    fm_write_t     fm_wr;       // transfer engine to fm store
    weight_write_t weight_wr;   // transfer engine to weight store

    data_trans_fp16 data_trans_inst (
        .clk          (clk),
        .rst          (rst),
        .layer_start  (layer_start),
        .layer_cfg    (layer_cfg),
        .update_start (update_start),
        .weight_req   (weight_req),
        .fm_wr        (fm_wr),
        .weight_wr    (weight_wr),
        .fm_done      (fm_done),
        .weight_done  (weight_done)
    );

    buffer_ram #(
        .width (fm_word_width),
        .depth (fm_depth)
    ) fm_buffer (
        .clk     (clk),
        .wr_en   (fm_wr.en),
        .wr_addr (fm_wr.addr),
        .wr_data (fm_wr.data),
        .rd_addr (fm_rd_addr),
        .rd_data (fm_rd_data)
    );

    buffer_ram #(
        .width (weight_word_width),
        .depth (weight_depth)
    ) weight_buffer (
        .clk     (clk),
        .wr_en   (weight_wr.en),
        .wr_addr (weight_wr.addr),
        .wr_data (weight_wr.data),
        .rd_addr (weight_rd_addr),
        .rd_data (weight_rd_data)
    );

endmodule

// File: source/cnn_params_pkg.sv
package cnn_params_pkg;

    localparam int data_width = 16;          // float16 element

    // feature-map tile parallelism
    localparam int para_x = 2;
    localparam int para_y = 2;
    localparam int fm_lanes = para_x * para_y;
    localparam int fm_word_width = fm_lanes * data_width;   // 64 bits

    // weight block geometry
    localparam int para_kernel = 2;          // kernels per weight block
    localparam int kernel_size_max = 3;
    localparam int weight_addr_step = kernel_size_max * kernel_size_max;
    localparam int weight_lanes = weight_addr_step * para_kernel;
    localparam int weight_word_width = weight_lanes * data_width;   // 288 bits

    // buffer sizes
    localparam int fm_depth = 64;
    localparam int fm_addr_width = 6;
    localparam int weight_depth = 512;
    localparam int weight_addr_width = 9;
    localparam int weight_ram_half = 256;    // start of upper weight half

    // counters and layer bookkeeping
    localparam int count_width = 8;
    localparam int layer_num_width = 4;

endpackage

// File: source/cnn_types_pkg.sv
package cnn_types_pkg;

    // 4 bits wide to match the existing layer-type field
    typedef enum logic [3:0] {
        layer_init = 4'd0,
        layer_conv = 4'd1,
        layer_pool = 4'd2
    } layer_type_e;

    // sampled at layer_start
    typedef struct packed {
        layer_type_e                                  layer_type;
        logic [cnn_params_pkg::layer_num_width-1:0]   layer_num;
        logic [cnn_params_pkg::count_width-1:0]       fm_count;       // fm words on init
        logic [cnn_params_pkg::count_width-1:0]       weight_count;   // weight words on init
        logic [cnn_params_pkg::count_width-1:0]       kernel_count;
    } layer_cfg_t;

    // sampled at update_start
    typedef struct packed {
        logic [cnn_params_pkg::weight_addr_width-1:0] base_addr;
        logic [cnn_params_pkg::count_width-1:0]       cur_count;      // while kernels remain
        logic [cnn_params_pkg::count_width-1:0]       next_count;     // preload for next layer
    } weight_req_t;

    typedef struct packed {
        logic                                         en;
        logic [cnn_params_pkg::fm_addr_width-1:0]     addr;
        logic [cnn_params_pkg::fm_word_width-1:0]     data;
    } fm_write_t;

    typedef struct packed {
        logic                                         en;
        logic [cnn_params_pkg::weight_addr_width-1:0] addr;
        logic [cnn_params_pkg::weight_word_width-1:0] data;
    } weight_write_t;

endpackage

// File: source/data_trans_fp16.sv
`timescale 1ns/1ps

module data_trans_fp16 (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          layer_start,
    input  cnn_types_pkg::layer_cfg_t     layer_cfg,
    input  logic                          update_start,
    input  cnn_types_pkg::weight_req_t    weight_req,
    output cnn_types_pkg::fm_write_t      fm_wr,
    output cnn_types_pkg::weight_write_t  weight_wr,
    output logic                          fm_done,
    output logic                          weight_done
);
    import cnn_params_pkg::*;
    import cnn_types_pkg::*;

    logic                         init_start;
    logic                         upd_start;
    logic                         wt_start;
    logic [count_width-1:0]       upd_count;
    logic [count_width-1:0]       wt_start_count;
    logic [count_width-1:0]       wt_half;

    layer_type_e                  cur_layer_type;
    logic [count_width-1:0]       kernels_left;

    logic [count_width-1:0]       fm_left;
    logic [15:0]                  fm_elem;
    logic                         fm_en;
    logic [fm_addr_width-1:0]     fm_addr;
    logic [fm_word_width-1:0]     fm_data;
    logic [15:0]                  fm_gen_base;
    logic [fm_word_width-1:0]     fm_ramp;

    logic [count_width-1:0]       wt_left;
    logic [15:0]                  wt_elem;
    logic [count_width-1:0]       wt_half_left;
    logic                         wt_swap;
    logic                         wt_to_upper;
    logic                         wt_en;
    logic [weight_addr_width-1:0] wt_addr;
    logic [weight_word_width-1:0] wt_data;
    logic [15:0]                  wt_gen_base;
    logic [weight_word_width-1:0] wt_ramp;

    assign init_start = layer_start && (layer_cfg.layer_type == layer_init);
    // updates only apply outside init layers
    assign upd_start = update_start && !init_start && (cur_layer_type != layer_init);
    assign wt_start = init_start || upd_start;

    assign upd_count = (kernels_left != '0) ? weight_req.cur_count : weight_req.next_count;
    assign wt_start_count = init_start ? layer_cfg.weight_count : upd_count;
    assign wt_half = layer_cfg.weight_count >> 1;   // lower half gets the rounded-down share

    // next write crosses into the upper weight half
    assign wt_to_upper = !wt_swap && (wt_half_left == '0);

    assign fm_gen_base = init_start ? 16'd0 : fm_elem;
    assign wt_gen_base = wt_start ? 16'd0 : wt_elem;

    fp16_ramp_gen #(.lanes(fm_lanes)) fm_ramp_gen (
        .base (fm_gen_base),
        .word (fm_ramp)
    );

    fp16_ramp_gen #(.lanes(weight_lanes)) weight_ramp_gen (
        .base (wt_gen_base),
        .word (wt_ramp)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cur_layer_type <= layer_init;
            kernels_left   <= '0;
        end else if (layer_start) begin
            cur_layer_type <= layer_cfg.layer_type;
            if (layer_cfg.layer_type != layer_init) begin
                kernels_left <= layer_cfg.kernel_count;
            end
        end else if (upd_start && (kernels_left != '0)) begin
            if (kernels_left > count_width'(para_kernel)) begin
                kernels_left <= kernels_left - count_width'(para_kernel);
            end else begin
                kernels_left <= '0;   // saturate
            end
        end
    end

    // feature-map stream
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fm_en   <= 1'b0;
            fm_done <= 1'b0;
            fm_left <= '0;
            fm_elem <= '0;
        end else if (init_start) begin
            fm_en   <= (layer_cfg.fm_count != '0);
            fm_done <= (layer_cfg.fm_count == '0);
            fm_left <= (layer_cfg.fm_count != '0) ? layer_cfg.fm_count - 1'b1 : '0;
            fm_elem <= 16'(fm_lanes);   // k = 1 is next
        end else if (fm_left != '0) begin
            fm_en   <= 1'b1;
            fm_left <= fm_left - 1'b1;
            fm_elem <= fm_elem + 16'(fm_lanes);
        end else if (fm_en) begin
            fm_en   <= 1'b0;   // last write just went out
            fm_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (init_start) begin
            fm_addr <= '0;
            fm_data <= fm_ramp;
        end else if (fm_left != '0) begin
            fm_addr <= fm_addr + 1'b1;
            fm_data <= fm_ramp;
        end
    end

    // weight stream, shared by init fill and updates
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wt_en        <= 1'b0;
            weight_done  <= 1'b0;
            wt_left      <= '0;
            wt_elem      <= '0;
            wt_half_left <= '0;
            wt_swap      <= 1'b0;
        end else if (wt_start) begin
            wt_en        <= (wt_start_count != '0);
            weight_done  <= (wt_start_count == '0);
            wt_left      <= (wt_start_count != '0) ? wt_start_count - 1'b1 : '0;
            wt_elem      <= 16'(weight_lanes);
            wt_half_left <= (init_start && (wt_half != '0)) ? wt_half - 1'b1 : '0;
            wt_swap      <= !(init_start && (wt_half != '0));   // updates never split
        end else if (wt_left != '0) begin
            wt_en   <= 1'b1;
            wt_left <= wt_left - 1'b1;
            wt_elem <= wt_elem + 16'(weight_lanes);
            if (wt_to_upper) begin
                wt_swap <= 1'b1;
            end else if (!wt_swap) begin
                wt_half_left <= wt_half_left - 1'b1;
            end
        end else if (wt_en) begin
            wt_en       <= 1'b0;
            weight_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wt_start) begin
            if (!init_start) begin
                wt_addr <= weight_req.base_addr;
            end else if (wt_half != '0) begin
                wt_addr <= '0;
            end else begin
                wt_addr <= weight_addr_width'(weight_ram_half);   // single word goes high
            end
            wt_data <= wt_ramp;
        end else if (wt_left != '0) begin
            if (wt_to_upper) begin
                wt_addr <= weight_addr_width'(weight_ram_half);
            end else begin
                wt_addr <= wt_addr + weight_addr_width'(weight_addr_step);   // wraps mod depth
            end
            wt_data <= wt_ramp;
        end
    end

    assign fm_wr     = '{en: fm_en, addr: fm_addr, data: fm_data};
    assign weight_wr = '{en: wt_en, addr: wt_addr, data: wt_data};

    assert property (@(posedge clk) disable iff (!rst) !(fm_wr.en && fm_done))
        else $error("fm write while fm_done is high");

    assert property (@(posedge clk) disable iff (!rst)
        weight_wr.en |-> (int'(weight_wr.addr) < weight_depth))
        else $error("weight write address out of range");

    // first fm write follows the init pulse directly
    assert property (@(posedge clk) disable iff (!rst)
        (layer_start && (layer_cfg.layer_type == layer_init) && (layer_cfg.fm_count != '0))
        |=> fm_wr.en)
        else $error("fm write missing after init layer_start");

endmodule

// File: source/fp16_ramp_gen.sv
`timescale 1ns/1ps

module fp16_ramp_gen #(
    parameter int lanes = cnn_params_pkg::fm_lanes
) (
    input  logic [15:0]                                base,   // element index of lane 0
    output logic [lanes*cnn_params_pkg::data_width-1:0] word
);
    import cnn_params_pkg::*;

    // exact float16 of an 11-bit unsigned integer
    function automatic logic [15:0] int_to_fp16(input logic [10:0] value);
        logic [3:0]  msb;
        logic [10:0] shifted;
        logic [15:0] result;
        msb = 4'd0;
        for (int b = 0; b < 11; b++) begin
            if (value[b]) begin
                msb = 4'(b);   // leading one wins, last hit is highest
            end
        end
        shifted = value << (4'd10 - msb);   // hidden bit lands on bit 10
        if (value == 11'd0) begin
            result = 16'h0000;
        end else begin
            result = {1'b0, 5'(msb) + 5'd15, shifted[9:0]};
        end
        return result;
    endfunction

    for (genvar i = 0; i < lanes; i++) begin : g_lane
        logic [10:0] elem;

        assign elem = base[10:0] + 11'(i);   // modulo 2048
        assign word[i*data_width +: data_width] = int_to_fp16(elem);
    end

endmodule
